//--- design/mod_arith_pkg.sv
// Modulus and Barrett constants for the residue pipeline.
// Import this package wherever data widths or reduction constants are needed.

package mod_arith_pkg;

  // ********************
  // data widths
  // ********************
  localparam int DAT_BITS = 16;                      // residue width
  localparam int IN_BITS  = 2 * DAT_BITS;            // double-width input

  // ********************
  // modulus
  // ********************
  localparam logic [DAT_BITS-1:0] MOD_P = 16'd65521; // largest 16-bit prime

  // ********************
  // Barrett reduction
  // ********************
  // k = half the bit length of P plus one, gives 9 here
  localparam int BAR_K = $clog2(MOD_P) / 2 + 1;

  // floor(2^(4k) / P), a 21-bit constant for P = 65521
  localparam longint unsigned BAR_U = (64'd1 << (4 * BAR_K)) / MOD_P;

  // bits kept for the final subtraction, enough for 0 .. 3P
  localparam int LOW_BITS = 2 * BAR_K + 2;

  // multiplier operand width, wide enough for either product
  localparam int OPR_BITS = IN_BITS;

endpackage

//--- design/stream_pkg.sv
// Stream-level definitions shared by the reduction pipe, the arbiter and
// the multiplier: tag width, latencies, FIFO depth and the request and
// response payloads that travel on the val/rdy links.

package stream_pkg;

  import mod_arith_pkg::*;

  // ********************
  // sizes
  // ********************
  localparam int CTL_BITS   = 8;   // user tag per item
  localparam int MUL_LAT    = 3;   // multiplier stages
  localparam int FIFO_DEPTH = 16;  // residue and route fifos

  // ********************
  // multiplier payloads
  // ********************
  // request: a * b, tag rides along untouched
  typedef struct packed {
    logic [OPR_BITS-1:0] a;
    logic [OPR_BITS-1:0] b;
    logic [CTL_BITS-1:0] ctl;
  } mult_req_t;

  // response: full-width product plus the request tag
  typedef struct packed {
    logic [2*OPR_BITS-1:0] dat;
    logic [CTL_BITS-1:0]   ctl;
  } mult_rsp_t;

  // ********************
  // arbiter ports
  // ********************
  typedef enum logic {
    PORT_0 = 1'b0,  // quotient estimate
    PORT_1 = 1'b1   // quotient times modulus
  } port_id_t;

endpackage

//--- design/stream_fifo.sv
// Synchronous FIFO with val/rdy on both sides. The payload type is a
// parameter, so the same block buffers residue low parts and port ids.
// Depth comes from the stream package.

`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  payload_t i_dat,
  input  logic     i_val,
  output logic     o_rdy,
  output payload_t o_dat,
  output logic     o_val,
  input  logic     i_rdy
);

  payload_t mem [stream_pkg::FIFO_DEPTH];                    // storage, no reset

  logic [$clog2(stream_pkg::FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(stream_pkg::FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(stream_pkg::FIFO_DEPTH):0]   count;         // one extra bit for full
  logic                                      push;
  logic                                      pop;

  assign o_rdy = (count != stream_pkg::FIFO_DEPTH);          // not full
  assign o_val = (count != '0);                              // not empty
  assign o_dat = mem[rd_ptr];                                // head, read ahead
  assign push  = i_val && o_rdy;
  assign pop   = o_val && i_rdy;

  // ********************
  // pointers and count
  // ********************
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == stream_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == stream_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                             // both or neither
      endcase
    end
  end

  // ********************
  // storage write
  // ********************
  always_ff @(posedge i_clk) begin
    if (push)
      mem[wr_ptr] <= i_dat;
  end

endmodule

//--- design/pipe_multiplier.sv
// Pipelined unsigned multiplier, MUL_LAT register stages deep.
// The tag travels beside the product. Under back-pressure the whole pipe
// freezes, so a product leaves MUL_LAT cycles after acceptance when idle.

`timescale 1ns/1ps

module pipe_multiplier
  import mod_arith_pkg::*, stream_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  mult_req_t i_req,
  input  logic      i_val,
  output logic      o_rdy,
  output mult_rsp_t o_rsp,
  output logic      o_val,
  input  logic      i_rdy
);

  // stage 0: two partial products, split on the low half of b
  logic [OPR_BITS+OPR_BITS/2-1:0] pp_lo;
  logic [OPR_BITS+OPR_BITS/2-1:0] pp_hi;
  logic [CTL_BITS-1:0]            pp_ctl;

  // stages 1 .. MUL_LAT-1: summed product, then plain delay
  mult_rsp_t          stg_rsp [1:MUL_LAT-1];
  logic [MUL_LAT-1:0] stg_val;                   // bit 0 is the partial-product stage
  logic               adv;

  // advance only if the last stage is empty or leaving
  assign adv   = ~stg_val[MUL_LAT-1] || i_rdy;
  assign o_rdy = adv;
  assign o_rsp = stg_rsp[MUL_LAT-1];
  assign o_val = stg_val[MUL_LAT-1];

  // ********************
  // valid chain
  // ********************
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      stg_val <= '0;
    end else if (adv) begin
      stg_val <= {stg_val[MUL_LAT-2:0], i_val};  // shift in new item
    end
  end

  // ********************
  // datapath
  // ********************
  always_ff @(posedge i_clk) begin
    if (adv) begin
      pp_lo  <= i_req.a * i_req.b[OPR_BITS/2-1:0];
      pp_hi  <= i_req.a * i_req.b[OPR_BITS-1:OPR_BITS/2];
      pp_ctl <= i_req.ctl;
      // recombine, high partial weighted by 2^(OPR_BITS/2)
      stg_rsp[1].dat <= (2*OPR_BITS)'(pp_lo)
                      + ((2*OPR_BITS)'(pp_hi) << (OPR_BITS / 2));
      stg_rsp[1].ctl <= pp_ctl;
      for (int i = 2; i < MUL_LAT; i++) begin
        stg_rsp[i] <= stg_rsp[i-1];              // delay to full latency
      end
    end
  end

endmodule

//--- design/mult_arbiter.sv
// Shares one multiplier between two request ports in round-robin order.
// The granted port id is queued in a route FIFO, and each product is sent
// back to the port at its head, so responses come back in grant order.
// No registers on the data path; only priority and route state.

`timescale 1ns/1ps

module mult_arbiter
  import stream_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  // request ports
  input  mult_req_t i_req_0,
  input  mult_req_t i_req_1,
  input  logic      i_req_val_0,
  input  logic      i_req_val_1,
  output logic      o_req_rdy_0,
  output logic      o_req_rdy_1,
  // toward multiplier
  output mult_req_t o_mul_req,
  output logic      o_mul_val,
  input  logic      i_mul_rdy,
  // from multiplier
  input  mult_rsp_t i_mul_rsp,
  input  logic      i_mul_val,
  output logic      o_mul_rdy,
  // response ports
  output mult_rsp_t o_rsp_0,
  output mult_rsp_t o_rsp_1,
  output logic      o_rsp_val_0,
  output logic      o_rsp_val_1,
  input  logic      i_rsp_rdy_0,
  input  logic      i_rsp_rdy_1
);

  logic     prio;        // 1: port 1 wins a tie
  port_id_t grant_port;
  port_id_t head_port;   // owner of the next product
  logic     any_req;
  logic     grant_ok;
  logic     route_rdy;
  logic     route_val;
  logic     route_pop;

  // ********************
  // request side
  // ********************
  assign any_req    = i_req_val_0 || i_req_val_1;
  assign grant_port = (i_req_val_1 && (~i_req_val_0 || prio)) ? PORT_1 : PORT_0;
  assign grant_ok   = route_rdy && i_mul_rdy;          // room to log the owner

  assign o_mul_req   = (grant_port == PORT_1) ? i_req_1 : i_req_0;
  assign o_mul_val   = any_req && route_rdy;
  assign o_req_rdy_0 = grant_ok && (grant_port == PORT_0);
  assign o_req_rdy_1 = grant_ok && (grant_port == PORT_1);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      prio <= 1'b0;
    end else if (i_req_val_0 && i_req_val_1 && grant_ok) begin
      prio <= ~prio;                                   // flip on contended grant
    end
  end

  // ********************
  // response side
  // ********************
  assign o_rsp_0     = i_mul_rsp;
  assign o_rsp_1     = i_mul_rsp;
  assign o_rsp_val_0 = i_mul_val && route_val && (head_port == PORT_0);
  assign o_rsp_val_1 = i_mul_val && route_val && (head_port == PORT_1);
  assign o_mul_rdy   = route_val && ((head_port == PORT_1) ? i_rsp_rdy_1 : i_rsp_rdy_0);
  assign route_pop   = i_mul_val && o_mul_rdy;

  // owner of every product in flight, in grant order
  stream_fifo #(
    .payload_t ( port_id_t )
  ) u_route_fifo (
    .i_clk ( i_clk              ),
    .i_rst ( i_rst              ),
    .i_dat ( grant_port         ),
    .i_val ( any_req && i_mul_rdy ),
    .o_rdy ( route_rdy          ),
    .o_dat ( head_port          ),
    .o_val ( route_val          ),
    .i_rdy ( route_pop          )
  );

endmodule

//--- design/barrett_reduce_pipe.sv
// Barrett reduction of a double-width value modulo MOD_P in four stages.
// Port 0 carries the quotient estimate product, port 1 the quotient times
// modulus product; both must be served by an external multiplier.
// Items leave in input order with their tags.

`timescale 1ns/1ps

module barrett_reduce_pipe
  import mod_arith_pkg::*, stream_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic [IN_BITS-1:0]  i_dat,
  input  logic [CTL_BITS-1:0] i_ctl,
  input  logic                i_val,
  output logic                o_rdy,
  output logic [DAT_BITS-1:0] o_dat,
  output logic [CTL_BITS-1:0] o_ctl,
  output logic                o_val,
  output logic                o_err,
  input  logic                i_rdy,
  // multiplier port 0
  output mult_req_t           o_mul_req_0,
  output logic                o_mul_val_0,
  input  logic                i_mul_rdy_0,
  input  mult_rsp_t           i_mul_rsp_0,
  input  logic                i_mul_val_0,
  output logic                o_mul_rdy_0,
  // multiplier port 1
  output mult_req_t           o_mul_req_1,
  output logic                o_mul_val_1,
  input  logic                i_mul_rdy_1,
  input  mult_rsp_t           i_mul_rsp_1,
  input  logic                i_mul_val_1,
  output logic                o_mul_rdy_1
);

  logic                s1_val, s2_val, s3_val;
  logic                half_busy;           // item between port 0 grant and stage 2 exit
  logic                xfer_0, xfer_1;
  logic                ld_1, ld_3, ld_4;
  logic [LOW_BITS-1:0] s3_dat;
  logic [CTL_BITS-1:0] s3_ctl;
  logic [LOW_BITS-1:0] low_dat;
  logic                low_rdy, low_val, low_pop;

  // ********************
  // stage 1: x >> (2k-2) times u
  // ********************
  // one item at a time in the first half, so a port 0 product always
  // finds stage 2 empty and never freezes the shared multiplier
  assign o_mul_val_0 = s1_val && ~half_busy;
  assign xfer_0      = o_mul_val_0 && i_mul_rdy_0;
  assign ld_1        = ~s1_val || xfer_0;
  assign o_rdy       = ld_1 && low_rdy;           // also need room for the low part

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val    <= 1'b0;
      half_busy <= 1'b0;
    end else begin
      if (ld_1)
        s1_val <= i_val && low_rdy;
      if (xfer_0)
        half_busy <= 1'b1;
      else if (xfer_1)
        half_busy <= 1'b0;                        // quotient handed to port 1
    end
  end

  always_ff @(posedge i_clk) begin
    if (ld_1) begin
      o_mul_req_0.a   <= i_dat >> (2 * BAR_K - 2);
      o_mul_req_0.b   <= OPR_BITS'(BAR_U);
      o_mul_req_0.ctl <= i_ctl;
    end
  end

  // ********************
  // stage 2: q3 = product >> (2k+2), times P
  // ********************
  assign o_mul_rdy_0 = ~s2_val;
  assign o_mul_val_1 = s2_val;
  assign xfer_1      = s2_val && i_mul_rdy_1;

  always_ff @(posedge i_clk) begin
    if (i_rst)
      s2_val <= 1'b0;
    else if (~s2_val)
      s2_val <= i_mul_val_0;
    else if (i_mul_rdy_1)
      s2_val <= 1'b0;
  end

  always_ff @(posedge i_clk) begin
    if (~s2_val) begin
      o_mul_req_1.a   <= OPR_BITS'(i_mul_rsp_0.dat >> (2 * BAR_K + 2));
      o_mul_req_1.b   <= OPR_BITS'(MOD_P);
      o_mul_req_1.ctl <= i_mul_rsp_0.ctl;
    end
  end

  // ********************
  // stage 3: low part minus low part of q3*P
  // ********************
  assign ld_3        = ~s3_val || ld_4;
  assign o_mul_rdy_1 = ld_3 && low_val;
  assign low_pop     = i_mul_val_1 && o_mul_rdy_1;

  always_ff @(posedge i_clk) begin
    if (i_rst)
      s3_val <= 1'b0;
    else if (ld_3)
      s3_val <= i_mul_val_1 && low_val;
  end

  always_ff @(posedge i_clk) begin
    if (ld_3) begin
      s3_dat <= low_dat - i_mul_rsp_1.dat[LOW_BITS-1:0];  // wraps mod 2^LOW_BITS
      s3_ctl <= i_mul_rsp_1.ctl;
    end
  end

  // ********************
  // stage 4: at most one subtraction of P
  // ********************
  assign ld_4 = ~o_val || i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
      o_err <= 1'b0;
    end else if (ld_4) begin
      o_val <= s3_val;
      if (s3_val && (s3_dat > 2 * MOD_P))
        o_err <= 1'b1;                            // sticky, estimate off by too much
    end
  end

  always_ff @(posedge i_clk) begin
    if (ld_4) begin
      o_dat <= (s3_dat >= MOD_P) ? DAT_BITS'(s3_dat - MOD_P) : DAT_BITS'(s3_dat);
      o_ctl <= s3_ctl;
    end
  end

  // low bits of each input, waiting for its q3*P product
  stream_fifo #(
    .payload_t ( logic [LOW_BITS-1:0] )
  ) u_low_fifo (
    .i_clk ( i_clk                ),
    .i_rst ( i_rst                ),
    .i_dat ( i_dat[LOW_BITS-1:0]  ),
    .i_val ( i_val && ld_1        ),
    .o_rdy ( low_rdy              ),
    .o_dat ( low_dat              ),
    .o_val ( low_val              ),
    .i_rdy ( low_pop              )
  );

endmodule

//--- design/barrett_reduce_top.sv
// Top level of the modular reduction unit. The reduction pipe's two
// multiplier ports share one pipelined multiplier through the arbiter.
// Input is any value below MOD_P squared; output is its residue.

`timescale 1ns/1ps

module barrett_reduce_top
  import mod_arith_pkg::*, stream_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic [IN_BITS-1:0]  i_dat,
  input  logic [CTL_BITS-1:0] i_ctl,
  input  logic                i_val,
  output logic                o_rdy,
  output logic [DAT_BITS-1:0] o_dat,
  output logic [CTL_BITS-1:0] o_ctl,
  output logic                o_val,
  output logic                o_err,
  input  logic                i_rdy
);

  // ********************
  // pipe <-> arbiter
  // ********************
  mult_req_t req_0, req_1;
  logic      req_val_0, req_val_1, req_rdy_0, req_rdy_1;
  mult_rsp_t rsp_0, rsp_1;
  logic      rsp_val_0, rsp_val_1, rsp_rdy_0, rsp_rdy_1;

  // ********************
  // arbiter <-> multiplier
  // ********************
  mult_req_t mul_req;
  logic      mul_req_val, mul_req_rdy;
  mult_rsp_t mul_rsp;
  logic      mul_rsp_val, mul_rsp_rdy;

  barrett_reduce_pipe u_barrett_reduce_pipe (
    .i_clk, .i_rst, .i_dat, .i_ctl, .i_val, .o_rdy,
    .o_dat, .o_ctl, .o_val, .o_err, .i_rdy,
    .o_mul_req_0 ( req_0     ), .o_mul_val_0 ( req_val_0 ), .i_mul_rdy_0 ( req_rdy_0 ),
    .i_mul_rsp_0 ( rsp_0     ), .i_mul_val_0 ( rsp_val_0 ), .o_mul_rdy_0 ( rsp_rdy_0 ),
    .o_mul_req_1 ( req_1     ), .o_mul_val_1 ( req_val_1 ), .i_mul_rdy_1 ( req_rdy_1 ),
    .i_mul_rsp_1 ( rsp_1     ), .i_mul_val_1 ( rsp_val_1 ), .o_mul_rdy_1 ( rsp_rdy_1 )
  );

  mult_arbiter u_mult_arbiter (
    .i_clk, .i_rst,
    .i_req_0     ( req_0       ), .i_req_1     ( req_1       ),
    .i_req_val_0 ( req_val_0   ), .i_req_val_1 ( req_val_1   ),
    .o_req_rdy_0 ( req_rdy_0   ), .o_req_rdy_1 ( req_rdy_1   ),
    .o_mul_req   ( mul_req     ), .o_mul_val   ( mul_req_val ), .i_mul_rdy ( mul_req_rdy ),
    .i_mul_rsp   ( mul_rsp     ), .i_mul_val   ( mul_rsp_val ), .o_mul_rdy ( mul_rsp_rdy ),
    .o_rsp_0     ( rsp_0       ), .o_rsp_1     ( rsp_1       ),
    .o_rsp_val_0 ( rsp_val_0   ), .o_rsp_val_1 ( rsp_val_1   ),
    .i_rsp_rdy_0 ( rsp_rdy_0   ), .i_rsp_rdy_1 ( rsp_rdy_1   )
  );

  pipe_multiplier u_pipe_multiplier (
    .i_clk, .i_rst,
    .i_req ( mul_req     ), .i_val ( mul_req_val ), .o_rdy ( mul_req_rdy ),
    .o_rsp ( mul_rsp     ), .o_val ( mul_rsp_val ), .i_rdy ( mul_rsp_rdy )
  );

endmodule

//--- verification/tb_barrett_reduce.sv
// Testbench for the Barrett reduction top level.
// Streams inputs from the test data file, checks residues, tags and order,
// then repeats the whole set under random input gaps and output stalls.

`timescale 1ns/1ps

module tb_barrett_reduce
  import mod_arith_pkg::*, stream_pkg::*;
;

  localparam int          MAX_LINES      = 64;
  localparam int          BOUNDARY_LINES = 7;             // leading boundary entries
  localparam logic [31:0] RNG_SEED       = 32'h69d7_d2de;

  logic                i_clk;
  logic                i_rst;
  logic [IN_BITS-1:0]  i_dat;
  logic [CTL_BITS-1:0] i_ctl;
  logic                i_val;
  logic                o_rdy;
  logic [DAT_BITS-1:0] o_dat;
  logic [CTL_BITS-1:0] o_ctl;
  logic                o_val;
  logic                o_err;
  logic                i_rdy;

  logic [55:0]                  test_mem [0:MAX_LINES-1];  // {input, tag, residue}
  logic [DAT_BITS+CTL_BITS-1:0] exp_q [$];                 // {residue, tag}, input order
  logic [DAT_BITS+CTL_BITS-1:0] mon_exp;
  string test_name = "reset_state";
  int    n_lines, err_count, test_errs, in_count, out_count;
  int    tests_run, tests_failed, cycle_count, cycle_limit, low_left;
  bit    bp_en, err_seen;

  barrett_reduce_top u_barrett_reduce_top (
    .i_clk ( i_clk ), .i_rst ( i_rst ), .i_dat ( i_dat ), .i_ctl ( i_ctl ),
    .i_val ( i_val ), .o_rdy ( o_rdy ), .o_dat ( o_dat ), .o_ctl ( o_ctl ),
    .o_val ( o_val ), .o_err ( o_err ), .i_rdy ( i_rdy )
  );

  always #2 i_clk = ~i_clk;                                 // 4 ns period

  // ********************
  // checks and bookkeeping
  // ********************
  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %0h, actual %0h", what, expected, actual);
      err_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = err_count;
    in_count  = 0;
    out_count = 0;
  endtask

  task automatic finish_test();
    while (exp_q.size() != 0) @(negedge i_clk);            // all results out
    repeat (8) @(negedge i_clk);                           // catch stray extra outputs
    check_value({test_name, " output count"}, in_count, out_count);
    tests_run++;
    if (err_count != test_errs) tests_failed++;
    $display("test %s %s  inputs %0d  outputs %0d", test_name,
             (err_count == test_errs) ? "ok" : "FAILED", in_count, out_count);
  endtask

  // ********************
  // stimulus
  // ********************
  // called and returns on a falling edge; holds i_val until accepted
  task automatic send_item(input int idx, input bit with_gaps);
    int          gap;
    logic [55:0] ent;
    ent = test_mem[idx];
    if (with_gaps) begin
      gap = $urandom % 3;
      if (gap != 0) begin
        i_val = 1'b0;
        repeat (gap) @(negedge i_clk);
      end
    end
    i_dat = ent[55:24];
    i_ctl = ent[23:16];
    i_val = 1'b1;
    exp_q.push_back({ent[15:0], ent[23:16]});               // residue and tag of this line
    in_count++;
    @(posedge i_clk);
    while (o_rdy !== 1'b1) @(posedge i_clk);               // handshake edge
    @(negedge i_clk);
  endtask

  task automatic check_idle_outputs();
    check_value({test_name, " o_val"}, 0, o_val);
    check_value({test_name, " o_err"}, 0, o_err);
    check_value({test_name, " o_rdy"}, 1, o_rdy);
  endtask

  // random low periods on the sink side while back-pressure is on
  always @(negedge i_clk) begin
    if (!bp_en) begin
      i_rdy = 1'b1;
    end else if (low_left > 0) begin
      i_rdy = 1'b0;
      low_left--;
    end else if ($urandom % 4 == 0) begin
      i_rdy    = 1'b0;
      low_left = $urandom % 4;                             // 1 to 4 cycles low
    end else begin
      i_rdy = 1'b1;
    end
  end

  // ********************
  // output monitor
  // ********************
  always @(posedge i_clk) begin
    if (!i_rst) begin
      if (o_err === 1'b1) err_seen = 1'b1;
      if (o_val === 1'b1 && i_rdy === 1'b1) begin
        out_count++;
        if (exp_q.size() == 0) begin
          $display("unexpected output in test %s: residue %0h with tag %0h, no input pending",
                   test_name, o_dat, o_ctl);
          err_count++;
        end else begin
          mon_exp = exp_q.pop_front();
          check_value({test_name, " residue"}, mon_exp[DAT_BITS+CTL_BITS-1:CTL_BITS], o_dat);
          check_value({test_name, " tag"}, mon_exp[CTL_BITS-1:0], o_ctl);
        end
      end
    end
  end

  // watchdog, limit set once the data file is loaded
  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run did not complete within %0d clock cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  // ********************
  // test sequence
  // ********************
  initial begin
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_dat = '0;
    i_ctl = '0;
    i_val = 1'b0;
    i_rdy = 1'b1;
    bp_en = 1'b0;
    void'($urandom(RNG_SEED));
    $readmemh("verification/barrett_testdata.hex", test_mem);
    n_lines = 0;
    while (n_lines < MAX_LINES && !$isunknown(test_mem[n_lines])) n_lines++;
    cycle_limit = 200 * n_lines + 100;
    if (n_lines <= BOUNDARY_LINES) begin
      $display("test data file holds only %0d lines, random entries missing", n_lines);
      err_count++;
    end

    start_test("reset_state");
    for (int c = 0; c < 4; c++) begin
      @(posedge i_clk);
      @(negedge i_clk);
      check_idle_outputs();                                // during reset
    end
    i_rst = 1'b0;
    @(negedge i_clk);
    check_idle_outputs();                                  // just after release
    finish_test();

    start_test("boundary");
    for (int i = 0; i < BOUNDARY_LINES && i < n_lines; i++) send_item(i, 1'b0);
    i_val = 1'b0;
    finish_test();

    start_test("random_stream");
    for (int i = BOUNDARY_LINES; i < n_lines; i++) send_item(i, 1'b0);
    i_val = 1'b0;
    finish_test();

    start_test("back_pressure");
    bp_en = 1'b1;
    for (int i = 0; i < n_lines; i++) send_item(i, 1'b1);
    i_val = 1'b0;
    finish_test();
    bp_en = 1'b0;

    start_test("error_flag");
    check_value("error_flag o_err at end", 0, o_err);
    check_value("error_flag o_err seen during run", 0, err_seen);
    finish_test();

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/mod_arith_pkg.sv
design/stream_pkg.sv
design/stream_fifo.sv
design/pipe_multiplier.sv
design/mult_arbiter.sv
design/barrett_reduce_pipe.sv
design/barrett_reduce_top.sv
verification/tb_barrett_reduce.sv

//--- verification/barrett_testdata.hex
// columns: input (32 bits) _ tag (8 bits) _ expected residue, input mod 65521 (16 bits)
// first seven lines are boundary values, the rest are pseudo-random inputs
00000000_3c_0000
00000001_5a_0001
0000fff0_81_fff0
0000fff1_ff_0000
0000fff2_00_0001
0001ffe2_7e_0000
ffe200e0_c3_fff0
12345678_a5_6793
deadbeef_11_cbd5
ffe20000_e7_ff10
00010000_42_000f
7fffffff_99_8068
00abcdef_2d_d7f4
80000000_b6_8069
cafef00d_68_d5a3
0badf00d_f0_9f3f
00ffffff_07_0eff
55555555_cc_559b
